//--- ex_mem_wb.f
+incdir+include
src/exb_pkg.sv
src/alu_lane.sv
src/operand_forward.sv
src/execute_stage.sv
src/memory_stage.sv
src/writeback_stage.sv
src/ex_mem_wb.sv
tb/tb_ex_mem_wb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_ex_mem_wb -f ex_mem_wb.f

result=$(./obj_dir/Vtb_ex_mem_wb 2>&1) || true
echo "$result"

if echo "$result" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1

//--- include/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

typedef exb_pkg::data_t rf_model_t [32];  // Model register file

function automatic exb_pkg::data_t xorshift32(input exb_pkg::data_t s);
    exb_pkg::data_t x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic exb_pkg::data_t ref_alu(input exb_pkg::alu_op_t op,
                                           input exb_pkg::data_t a,
                                           input exb_pkg::data_t b);
    case (op)
        exb_pkg::alu_add: return a + b;
        exb_pkg::alu_sub: return a - b;
        exb_pkg::alu_and: return a & b;
        exb_pkg::alu_or:  return a | b;
        exb_pkg::alu_xor: return a ^ b;
        exb_pkg::alu_sll: return a << b[4:0];
        exb_pkg::alu_srl: return a >> b[4:0];
        exb_pkg::alu_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        default:          return '0;
    endcase
endfunction

function automatic exb_pkg::data_t rf_read(input rf_model_t rf,
                                           input exb_pkg::reg_addr_t addr);
    return (addr == '0) ? '0 : rf[addr];  // r0 is hardwired
endfunction

`endif

//--- tb/tb_ex_mem_wb.sv
`timescale 1ns/1ps

module tb_ex_mem_wb;

    localparam int num_pairs      = 400;
    localparam int timeout_cycles = num_pairs * 6 + 100;
    localparam int drain_cycles   = 20;

    `include "tb_model.svh"

    logic               clk;
    logic               arst_n;
    exb_pkg::issue_t    issue_a;
    exb_pkg::issue_t    issue_b;
    exb_pkg::mem_kind_t mem_kind_b;
    logic               mem_ready;
    exb_pkg::data_t     mem_rdata;
    logic               stall;
    logic               mem_valid;
    logic               mem_we;
    exb_pkg::data_t     mem_addr;
    exb_pkg::data_t     mem_wdata;
    exb_pkg::wb_t       wb_a;
    exb_pkg::wb_t       wb_b;

    rf_model_t          model_rf;        // Written only from DUT write-back
    rf_model_t          arch_rf;         // Updated at issue
    exb_pkg::data_t     arch_mem [64];
    exb_pkg::data_t     resp_mem [64];   // Memory responder contents
    exb_pkg::wb_t       exp_a [$];
    exb_pkg::wb_t       exp_b [$];
    exb_pkg::data_t     exp_st_addr [$];
    exb_pkg::data_t     exp_st_data [$];
    exb_pkg::data_t     seed;
    exb_pkg::reg_addr_t blocked;         // Load dest of the previous pair
    exb_pkg::mem_kind_t kind_in_mem;     // Kind of the pair now in MEM
    logic               accepted;
    logic               reset_checked;
    int                 issued;
    int                 cycle_count = 0;

    ex_mem_wb i_dut (.*);

    assign mem_rdata = resp_mem[mem_addr[7:2]];  // Same-cycle read data

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_cycles) begin
            stop_with_failure($sformatf("Timeout: run not finished after %0d cycles",
                                        timeout_cycles));
        end
    end

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1, "Run stopped at first failure");
    endtask

    function automatic exb_pkg::data_t next_random();
        seed = xorshift32(seed);
        return seed;
    endfunction

    // Steps past registers the issue rules forbid
    function automatic exb_pkg::reg_addr_t pick_src(input exb_pkg::reg_addr_t r,
                                                    input exb_pkg::reg_addr_t avoid1,
                                                    input exb_pkg::reg_addr_t avoid2);
        exb_pkg::reg_addr_t s;
        s = r;
        while (s != '0 && (s == avoid1 || s == avoid2)) begin
            s = s + 5'd1;
        end
        return s;
    endfunction

    task automatic check_level(input string what, input logic got, input logic want);
        if (got !== want) begin
            stop_with_failure($sformatf("** Error at %0t ns: %s is %b, expected %b",
                                        $time, what, got, want));
        end
    endtask

    task automatic compare_wb(input int lane, input exb_pkg::wb_t got);
        exb_pkg::wb_t want;
        logic         found;
        found = 1'b0;
        if (lane == 0 && exp_a.size() != 0) begin
            want  = exp_a.pop_front();
            found = 1'b1;
        end else if (lane == 1 && exp_b.size() != 0) begin
            want  = exp_b.pop_front();
            found = 1'b1;
        end
        if (!found) begin
            stop_with_failure($sformatf("Lane %0d wrote r%0d at %0t ns with no write pending",
                                        lane, got.waddr, $time));
        end else if (got.waddr != want.waddr || got.wdata != want.wdata) begin
            stop_with_failure($sformatf("** Error at %0t ns: lane %0d wrote r%0d = %h, %s",
                                        $time, lane, got.waddr, got.wdata,
                                        $sformatf("expected r%0d = %h", want.waddr, want.wdata)));
        end
    endtask

    task automatic compare_store(input exb_pkg::data_t addr, input exb_pkg::data_t data);
        exb_pkg::data_t want_addr;
        exb_pkg::data_t want_data;
        if (exp_st_addr.size() == 0) begin
            stop_with_failure($sformatf("Unexpected store to %h at %0t ns", addr, $time));
        end else begin
            want_addr = exp_st_addr.pop_front();
            want_data = exp_st_data.pop_front();
            if (addr != want_addr || data != want_data) begin
                stop_with_failure($sformatf("** Error at %0t ns: store %h to %h, expected %h to %h",
                                            $time, data, addr, want_data, want_addr));
            end
        end
    endtask

    // Draws a pair and derives its results from the architectural state
    task automatic make_pair();
        exb_pkg::issue_t    ia;
        exb_pkg::issue_t    ib;
        exb_pkg::mem_kind_t kind;
        exb_pkg::data_t     r;
        exb_pkg::data_t     res_a;
        exb_pkg::data_t     addr_b;
        exb_pkg::data_t     res_b;
        exb_pkg::data_t     rs2_b;
        exb_pkg::reg_addr_t avoid_b;
        ia = '0;
        ib = '0;
        r  = next_random();
        ia.rf_we   = (r[2:0] != 3'd0);
        ia.waddr   = {2'b00, r[5:3]};   // Few registers, many hazards
        ia.raddr1  = pick_src({2'b00, r[8:6]}, blocked, 5'd0);
        ia.raddr2  = pick_src({2'b00, r[11:9]}, blocked, 5'd0);
        ia.use_imm = r[12];
        ia.alu_op  = {1'b0, r[15:13]};
        ia.imm     = next_random();
        avoid_b    = ia.rf_we ? ia.waddr : 5'd0;
        r = next_random();
        kind = (r[2:1] == 2'b00) ? exb_pkg::mem_load :
               (r[2:0] == 3'd2) ? exb_pkg::mem_store : exb_pkg::mem_none;
        ib.rf_we   = (r[5:3] != 3'd0) || (kind == exb_pkg::mem_load);
        ib.waddr   = {2'b00, r[8:6]};
        ib.raddr1  = pick_src({2'b00, r[11:9]}, blocked, avoid_b);
        ib.raddr2  = pick_src({2'b00, r[14:12]}, blocked, avoid_b);
        ib.use_imm = r[15] || (kind != exb_pkg::mem_none);
        ib.alu_op  = (kind != exb_pkg::mem_none) ? exb_pkg::alu_add : {1'b0, r[18:16]};
        ib.imm     = next_random();
        res_a  = ref_alu(ia.alu_op, rf_read(arch_rf, ia.raddr1),
                         ia.use_imm ? ia.imm : rf_read(arch_rf, ia.raddr2));
        rs2_b  = rf_read(arch_rf, ib.raddr2);
        addr_b = ref_alu(ib.alu_op, rf_read(arch_rf, ib.raddr1), ib.use_imm ? ib.imm : rs2_b);
        res_b  = (kind == exb_pkg::mem_load) ? arch_mem[addr_b[7:2]] : addr_b;
        if (kind == exb_pkg::mem_store) begin
            exp_st_addr.push_back(addr_b);
            exp_st_data.push_back(rs2_b);
            arch_mem[addr_b[7:2]] = rs2_b;
        end
        if (ia.rf_we) begin
            exp_a.push_back(exb_pkg::wb_t'{we: 1'b1, waddr: ia.waddr, wdata: res_a});
            arch_rf[ia.waddr] = (ia.waddr == '0) ? '0 : res_a;
        end
        if (ib.rf_we && kind != exb_pkg::mem_store) begin
            exp_b.push_back(exb_pkg::wb_t'{we: 1'b1, waddr: ib.waddr, wdata: res_b});
            arch_rf[ib.waddr] = (ib.waddr == '0) ? '0 : res_b;  // Lane B wins
        end
        blocked    = (kind == exb_pkg::mem_load) ? ib.waddr : 5'd0;
        issue_a    = ia;
        issue_b    = ib;
        mem_kind_b = kind;
    endtask

    task automatic drive_cycle(input logic idle);
        exb_pkg::data_t r;
        if (idle) begin
            issue_a    = '0;
            issue_b    = '0;
            mem_kind_b = exb_pkg::mem_none;
        end
        issue_a.rdata1 = rf_read(model_rf, issue_a.raddr1);  // Stale as in a real RF
        issue_a.rdata2 = rf_read(model_rf, issue_a.raddr2);
        issue_b.rdata1 = rf_read(model_rf, issue_b.raddr1);
        issue_b.rdata2 = rf_read(model_rf, issue_b.raddr2);
        r = next_random();
        mem_ready = (r[1:0] != 2'b00);  // Low about a quarter of the time
    endtask

    task automatic finish_cycle();
        logic want_valid;
        @(negedge clk);
        want_valid = (kind_in_mem != exb_pkg::mem_none);
        if (!arst_n || !reset_checked) begin
            check_level("stall", stall, 1'b0);
            check_level("mem_valid", mem_valid, 1'b0);
            check_level("wb_a.we", wb_a.we, 1'b0);
            check_level("wb_b.we", wb_b.we, 1'b0);
            reset_checked = arst_n;
        end else begin
            check_level("mem_valid", mem_valid, want_valid);
            check_level("mem_we", mem_we, kind_in_mem == exb_pkg::mem_store);
            check_level("stall", stall, want_valid && !mem_ready);
            if (wb_a.we) begin
                compare_wb(0, wb_a);
            end
            if (wb_b.we) begin
                compare_wb(1, wb_b);
            end
            if (wb_a.we && wb_a.waddr != '0) begin
                model_rf[wb_a.waddr] = wb_a.wdata;
            end
            if (wb_b.we && wb_b.waddr != '0) begin
                model_rf[wb_b.waddr] = wb_b.wdata;
            end
            if (mem_valid && mem_we && mem_ready) begin
                compare_store(mem_addr, mem_wdata);
                resp_mem[mem_addr[7:2]] = mem_wdata;
            end
        end
        accepted = !stall;
        if (accepted) begin
            kind_in_mem = mem_kind_b;  // Pair in EX moves on at the next edge
        end
    endtask

    initial begin
        clk           = 1'b0;
        arst_n        = 1'b0;
        mem_ready     = 1'b0;
        issue_a       = '0;
        issue_b       = '0;
        mem_kind_b    = exb_pkg::mem_none;
        seed          = 32'h7b6d;
        blocked       = '0;
        kind_in_mem   = exb_pkg::mem_none;
        accepted      = 1'b1;
        reset_checked = 1'b0;
        issued        = 0;
        for (int i = 0; i < 32; i++) begin
            model_rf[i] = '0;
            arch_rf[i]  = '0;
        end
        for (int i = 0; i < 64; i++) begin
            arch_mem[i] = exb_pkg::data_t'(i) * 32'h9e3779b1 ^ 32'h0badf00d;
            resp_mem[i] = arch_mem[i];
        end
        repeat (16) begin
            @(posedge clk);
            #1;
            drive_cycle(1'b1);
            finish_cycle();
        end
        @(posedge clk);
        #1;
        arst_n = 1'b1;
        drive_cycle(1'b1);
        finish_cycle();
        while (!(issued == num_pairs && accepted)) begin
            @(posedge clk);
            #1;
            if (accepted) begin
                make_pair();  // Otherwise hold the stalled pair
                issued = issued + 1;
            end
            drive_cycle(1'b0);
            finish_cycle();
        end
        repeat (drain_cycles) begin
            @(posedge clk);
            #1;
            drive_cycle(1'b1);
            finish_cycle();
        end
        if (exp_a.size() != 0 || exp_b.size() != 0 || exp_st_addr.size() != 0) begin
            stop_with_failure($sformatf("Results missing at end: %0d lane A, %0d lane B, %0d stores",
                                        exp_a.size(), exp_b.size(), exp_st_addr.size()));
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

//--- src/ex_mem_wb.sv
`timescale 1ns/1ps

module ex_mem_wb (
    input  logic               clk,
    input  logic               arst_n,
    input  exb_pkg::issue_t    issue_a,
    input  exb_pkg::issue_t    issue_b,
    input  exb_pkg::mem_kind_t mem_kind_b,
    input  logic               mem_ready,
    input  exb_pkg::data_t     mem_rdata,
    output logic               stall,
    output logic               mem_valid,
    output logic               mem_we,
    output exb_pkg::data_t     mem_addr,
    output exb_pkg::data_t     mem_wdata,
    output exb_pkg::wb_t       wb_a,
    output exb_pkg::wb_t       wb_b
);

    exb_pkg::ex_mem_t ex_mem;         // EX to MEM payload
    exb_pkg::wb_t     mem_res_a;
    exb_pkg::wb_t     mem_res_b;
    logic             forwardable_b;  // Low for a load in MEM

    execute_stage i_execute (
        .issue_a       (issue_a),
        .issue_b       (issue_b),
        .mem_kind_b    (mem_kind_b),
        .mem_res_a     (mem_res_a),
        .mem_res_b     (mem_res_b),
        .forwardable_b (forwardable_b),
        .wb_a          (wb_a),
        .wb_b          (wb_b),
        .ex_out        (ex_mem)
    );

    memory_stage i_memory (
        .clk           (clk),
        .arst_n        (arst_n),
        .ex_in         (ex_mem),
        .mem_ready     (mem_ready),
        .mem_rdata     (mem_rdata),
        .mem_valid     (mem_valid),
        .mem_we        (mem_we),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .stall         (stall),
        .mem_res_a     (mem_res_a),
        .mem_res_b     (mem_res_b),
        .forwardable_b (forwardable_b)
    );

    writeback_stage i_writeback (
        .clk       (clk),
        .arst_n    (arst_n),
        .stall     (stall),
        .mem_res_a (mem_res_a),
        .mem_res_b (mem_res_b),
        .wb_a      (wb_a),
        .wb_b      (wb_b)
    );

endmodule

//--- src/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         stall,
    input  exb_pkg::wb_t mem_res_a,
    input  exb_pkg::wb_t mem_res_b,
    output exb_pkg::wb_t wb_a,
    output exb_pkg::wb_t wb_b
);

    logic               we_a_q;
    logic               we_b_q;
    exb_pkg::reg_addr_t waddr_a_q;
    exb_pkg::reg_addr_t waddr_b_q;
    exb_pkg::data_t     wdata_a_q;
    exb_pkg::data_t     wdata_b_q;

    // Bubble while MEM holds, so each write shows once
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            we_a_q <= 1'b0;
            we_b_q <= 1'b0;
        end else begin
            we_a_q <= mem_res_a.we && !stall;
            we_b_q <= mem_res_b.we && !stall;
        end
    end

    always_ff @(posedge clk) begin
        waddr_a_q <= mem_res_a.waddr;
        waddr_b_q <= mem_res_b.waddr;
        wdata_a_q <= mem_res_a.wdata;
        wdata_b_q <= mem_res_b.wdata;
    end

    assign wb_a = '{we: we_a_q, waddr: waddr_a_q, wdata: wdata_a_q};
    assign wb_b = '{we: we_b_q, waddr: waddr_b_q, wdata: wdata_b_q};

endmodule

//--- src/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
    input  logic             clk,
    input  logic             arst_n,
    input  exb_pkg::ex_mem_t ex_in,
    input  logic             mem_ready,
    input  exb_pkg::data_t   mem_rdata,
    output logic             mem_valid,
    output logic             mem_we,
    output exb_pkg::data_t   mem_addr,
    output exb_pkg::data_t   mem_wdata,
    output logic             stall,
    output exb_pkg::wb_t     mem_res_a,
    output exb_pkg::wb_t     mem_res_b,
    output logic             forwardable_b
);

    exb_pkg::mem_kind_t kind_q;
    logic               we_a_q;
    logic               we_b_q;
    exb_pkg::reg_addr_t waddr_a_q;
    exb_pkg::reg_addr_t waddr_b_q;
    exb_pkg::data_t     result_a_q;
    exb_pkg::data_t     result_b_q;
    exb_pkg::data_t     store_q;
    logic               is_load;
    logic               is_store;

    // EX/MEM control, held while memory is busy
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            kind_q <= exb_pkg::mem_none;
            we_a_q <= 1'b0;
            we_b_q <= 1'b0;
        end else if (!stall) begin
            kind_q <= ex_in.mem_kind;
            we_a_q <= ex_in.lane_a.we;
            we_b_q <= ex_in.lane_b.we;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            waddr_a_q  <= ex_in.lane_a.waddr;
            waddr_b_q  <= ex_in.lane_b.waddr;
            result_a_q <= ex_in.lane_a.wdata;
            result_b_q <= ex_in.lane_b.wdata;
            store_q    <= ex_in.store_data;
        end
    end

    assign is_load  = (kind_q == exb_pkg::mem_load);
    assign is_store = (kind_q == exb_pkg::mem_store);

    assign mem_valid = is_load || is_store;
    assign mem_we    = is_store;
    assign mem_addr  = result_b_q;
    assign mem_wdata = store_q;
    assign stall     = mem_valid && !mem_ready;  // Same-cycle answer from memory

    assign mem_res_a = '{we: we_a_q, waddr: waddr_a_q, wdata: result_a_q};
    assign mem_res_b = '{we: we_b_q, waddr: waddr_b_q,
                         wdata: is_load ? mem_rdata : result_b_q};

    // Load data arrives too late for the EX bypass
    assign forwardable_b = !is_load;

endmodule

//--- src/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  exb_pkg::issue_t    issue_a,
    input  exb_pkg::issue_t    issue_b,
    input  exb_pkg::mem_kind_t mem_kind_b,
    input  exb_pkg::wb_t       mem_res_a,
    input  exb_pkg::wb_t       mem_res_b,
    input  logic               forwardable_b,
    input  exb_pkg::wb_t       wb_a,
    input  exb_pkg::wb_t       wb_b,
    output exb_pkg::ex_mem_t   ex_out
);

    exb_pkg::data_t src_a1;
    exb_pkg::data_t src_a2;
    exb_pkg::data_t src_b1;
    exb_pkg::data_t src_b2;  // Also the store data
    exb_pkg::data_t result_a;
    exb_pkg::data_t result_b;
    logic           is_store;

    operand_forward i_fwd_a1 (.raddr(issue_a.raddr1), .rf_data(issue_a.rdata1),
        .mem_a(mem_res_a), .mem_b(mem_res_b), .wb_a(wb_a), .wb_b(wb_b),
        .forwardable_b(forwardable_b), .data(src_a1));
    operand_forward i_fwd_a2 (.raddr(issue_a.raddr2), .rf_data(issue_a.rdata2),
        .mem_a(mem_res_a), .mem_b(mem_res_b), .wb_a(wb_a), .wb_b(wb_b),
        .forwardable_b(forwardable_b), .data(src_a2));
    operand_forward i_fwd_b1 (.raddr(issue_b.raddr1), .rf_data(issue_b.rdata1),
        .mem_a(mem_res_a), .mem_b(mem_res_b), .wb_a(wb_a), .wb_b(wb_b),
        .forwardable_b(forwardable_b), .data(src_b1));
    operand_forward i_fwd_b2 (.raddr(issue_b.raddr2), .rf_data(issue_b.rdata2),
        .mem_a(mem_res_a), .mem_b(mem_res_b), .wb_a(wb_a), .wb_b(wb_b),
        .forwardable_b(forwardable_b), .data(src_b2));

    alu_lane i_alu_a (.issue(issue_a), .src1(src_a1), .src2(src_a2), .result(result_a));
    alu_lane i_alu_b (.issue(issue_b), .src1(src_b1), .src2(src_b2), .result(result_b));

    assign is_store = (mem_kind_b == exb_pkg::mem_store);

    assign ex_out.lane_a.we    = issue_a.rf_we;
    assign ex_out.lane_a.waddr = issue_a.waddr;
    assign ex_out.lane_a.wdata = result_a;
    assign ex_out.lane_b.we    = issue_b.rf_we && !is_store;  // Stores never write the RF
    assign ex_out.lane_b.waddr = issue_b.waddr;
    assign ex_out.lane_b.wdata = result_b;                    // Address for loads and stores
    assign ex_out.mem_kind     = mem_kind_b;
    assign ex_out.store_data   = src_b2;

endmodule

//--- src/operand_forward.sv
`timescale 1ns/1ps

module operand_forward (
    input  exb_pkg::reg_addr_t raddr,
    input  exb_pkg::data_t     rf_data,
    input  exb_pkg::wb_t       mem_a,
    input  exb_pkg::wb_t       mem_b,
    input  exb_pkg::wb_t       wb_a,
    input  exb_pkg::wb_t       wb_b,
    input  logic               forwardable_b,
    output exb_pkg::data_t     data
);

    logic hit_mem_b;
    logic hit_mem_a;
    logic hit_wb_b;
    logic hit_wb_a;
    logic is_zero;

    assign is_zero = (raddr == '0);

    // A pending load in MEM lane B has no data yet
    assign hit_mem_b = mem_b.we && forwardable_b && (mem_b.waddr == raddr);
    assign hit_mem_a = mem_a.we && (mem_a.waddr == raddr);
    assign hit_wb_b  = wb_b.we && (wb_b.waddr == raddr);
    assign hit_wb_a  = wb_a.we && (wb_a.waddr == raddr);

    // Younger results win, lane B over lane A within a pair
    always_comb begin
        if (is_zero) begin
            data = '0;
        end else if (hit_mem_b) begin
            data = mem_b.wdata;
        end else if (hit_mem_a) begin
            data = mem_a.wdata;
        end else if (hit_wb_b) begin
            data = wb_b.wdata;
        end else if (hit_wb_a) begin
            data = wb_a.wdata;
        end else begin
            data = rf_data;  // No newer write in flight
        end
    end

endmodule

//--- src/alu_lane.sv
`timescale 1ns/1ps

module alu_lane (
    input  exb_pkg::issue_t issue,
    input  exb_pkg::data_t  src1,
    input  exb_pkg::data_t  src2,
    output exb_pkg::data_t  result
);

    exb_pkg::data_t op2;    // Operand 2 after immediate select
    logic [4:0]     shamt;
    logic           lt;     // Signed less-than

    assign op2   = issue.use_imm ? issue.imm : src2;
    assign shamt = op2[4:0];
    assign lt    = $signed(src1) < $signed(op2);

    always_comb begin
        case (issue.alu_op)
            exb_pkg::alu_add: begin
                result = src1 + op2;
            end
            exb_pkg::alu_sub: begin
                result = src1 - op2;
            end
            exb_pkg::alu_and: begin
                result = src1 & op2;
            end
            exb_pkg::alu_or: begin
                result = src1 | op2;
            end
            exb_pkg::alu_xor: begin
                result = src1 ^ op2;
            end
            exb_pkg::alu_sll: begin
                result = src1 << shamt;
            end
            exb_pkg::alu_srl: begin
                result = src1 >> shamt;  // Logical, zero fill
            end
            exb_pkg::alu_slt: begin
                result = lt ? exb_pkg::data_t'(1) : '0;
            end
            default: begin
                result = '0;             // Unused codes give zero
            end
        endcase
    end

endmodule

//--- src/exb_pkg.sv
package exb_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 4;
    localparam int mem_kind_w = 2;

    typedef logic [data_w-1:0]     data_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;  // Index zero reads as zero
    typedef logic [alu_op_w-1:0]   alu_op_t;
    typedef logic [mem_kind_w-1:0] mem_kind_t;

    localparam alu_op_t alu_add = 4'd0;
    localparam alu_op_t alu_sub = 4'd1;
    localparam alu_op_t alu_and = 4'd2;
    localparam alu_op_t alu_or  = 4'd3;
    localparam alu_op_t alu_xor = 4'd4;
    localparam alu_op_t alu_sll = 4'd5;  // Shift amount from low five bits
    localparam alu_op_t alu_srl = 4'd6;
    localparam alu_op_t alu_slt = 4'd7;  // Signed compare

    localparam mem_kind_t mem_none  = 2'd0;
    localparam mem_kind_t mem_load  = 2'd1;
    localparam mem_kind_t mem_store = 2'd2;

    typedef struct packed {
        logic      rf_we;
        reg_addr_t waddr;
        reg_addr_t raddr1;
        reg_addr_t raddr2;
        data_t     rdata1;   // Register file value, may be stale
        data_t     rdata2;
        data_t     imm;
        logic      use_imm;  // Immediate replaces rs2 as operand 2
        alu_op_t   alu_op;
    } issue_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        data_t     wdata;
    } wb_t;

    typedef struct packed {
        wb_t       lane_a;      // wdata is the ALU result
        wb_t       lane_b;      // ALU result doubles as memory address
        mem_kind_t mem_kind;
        data_t     store_data;  // Forwarded rs2 of lane B
    } ex_mem_t;

endpackage
